/* microCore.f */
microPkg.sv
instrRom.sv
instructionFetch.sv
execUnit.sv
microCore.sv
microCore_props.sv
tbMicroCore.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and pass only when the pass line is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tbMicroCore -f microCore.f \
	&& ./obj_dir/VtbMicroCore \
	| awk '{ print } /^Regression passed$/ { ok = 1 } END { exit !ok }' \
	|| exit 1

/* tbMicroCore.sv */
`timescale 1ns/1ps

module tbMicroCore;
	import microPkg::*;

	localparam int addrWidth = 8;
	localparam int numTests = 20;
	// Programs rotate through four slots of this many words
	localparam int slotWords = 64;
	// Bound on the cycles of the longest generated program
	localparam int longestCycles = 600;

	typedef logic [addrWidth-1:0] addrT;

	logic IsCall;
	logic rstN;
	logic progWe;
	addrT progAddr;
	instrT progData;
	logic start;
	addrT startAddr;
	logic resultValid;
	dataT resultData;
	logic programDone;

	logic [31:0] rngState = 32'd26;
	instrT progWords[$];
	// Everything written into the ROM so far
	instrT romImage [1 << addrWidth];
	// Model registers persist across programs like the DUT's
	dataT modelRegs [4] = '{default: '0};
	dataT expEmits[$];
	int errorCount = 0;
	int checkCount = 0;
	int testErrors = 0;

	microCore #(.addrWidth(addrWidth)) microCore_i (.*);

	initial begin
		IsCall = 1'b0;
		forever begin
			#5 IsCall = ~IsCall;
		end
	end

	// Watchdog over all tests
	initial begin
		#(numTests * longestCycles * 4 * 10);
		$display("Watchdog expired before the last test finished");
		$display("Regression failed");
		$finish;
	end

	// Xorshift32 step, result reduced to 0..n-1
	function automatic int randBelow(input int n);
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return int'(rngState % 32'(n));
	endfunction

	function automatic instrT encode(input opcodeT op, input int r, input int imm, input int tgt);
		instrT w;
		w = '0;
		w[31:28] = op;
		w[27:26] = 2'(r);
		w[23:16] = 8'(imm);
		w[addrWidth-1:0] = addrT'(tgt);
		return w;
	endfunction

	// Random blocks, one call somewhere among them, then the final return
	task automatic genProgram(input int base);
		int blocks;
		int callAt;
		int callIdx;
		int skipIdx;
		int top;
		int a;
		int b;
		int k;
		progWords.delete();
		blocks = 2 + randBelow(4);
		callAt = randBelow(blocks + 1);
		callIdx = 0;
		for (int i = 0; i <= blocks; i++) begin
			a = randBelow(4);
			b = (a + 1 + randBelow(3)) % 4;
			if (i == callAt) begin
				// Emits on both sides show where the return resumes
				progWords.push_back(encode(opEmit, a, 0, 0));
				callIdx = progWords.size();
				progWords.push_back('0);
				progWords.push_back(encode(opEmit, b, 0, 0));
			end
			case (i < blocks ? randBelow(3) : 3)
				0: begin
					repeat (1 + randBelow(4)) begin
						k = randBelow(3);
						progWords.push_back(encode(k == 2 ? opEmit : opcodeT'(k + 1),
							randBelow(4), randBelow(256), 0));
					end
				end
				1: begin
					// Counter cleared, set to 1..5, counted down by the loop
					progWords.push_back(encode(opMuli, a, 0, 0));
					progWords.push_back(encode(opAddi, a, 1 + randBelow(5), 0));
					top = base + progWords.size();
					progWords.push_back(encode(opAddi, b, randBelow(256), 0));
					progWords.push_back(encode(opEmit, b, 0, 0));
					progWords.push_back(encode(opDec, a, 0, 0));
					progWords.push_back(encode(opBnz, a, 0, top));
				end
				2: begin
					// Forward skip, never taken right after a clear
					if (randBelow(2) == 0) begin
						progWords.push_back(encode(opMuli, a, 0, 0));
					end
					skipIdx = progWords.size();
					progWords.push_back('0);
					repeat (1 + randBelow(2)) begin
						progWords.push_back(encode(opEmit, randBelow(4), 0, 0));
					end
					progWords[skipIdx] = encode(opBnz, a, 0, base + progWords.size());
				end
				default: begin
				end
			endcase
		end
		progWords.push_back(encode(opRet, 0, 0, 0));
		// Subroutine sits after the final return
		progWords[callIdx] = encode(opCall, 0, 0, base + progWords.size());
		progWords.push_back(encode(opAddi, a, randBelow(256), 0));
		progWords.push_back(encode(opEmit, a, 0, 0));
		progWords.push_back(encode(opRet, 0, 0, 0));
	endtask

	// ISA interpreter over the ROM image, fills expEmits
	task automatic runModel(input addrT pc, output int steps);
		addrT retReg;
		logic pend;
		instrT w;
		regSelT r;
		dataT imm;
		expEmits.delete();
		pend = 1'b0;
		retReg = '0;
		for (steps = 1; steps < longestCycles; steps++) begin
			w = romImage[pc];
			r = w[27:26];
			imm = dataT'(w[23:16]);
			pc = pc + 1'b1;
			case (w[31:28])
				opAddi: modelRegs[r] = modelRegs[r] + imm;
				opMuli: modelRegs[r] = modelRegs[r] * imm;
				opDec: modelRegs[r] = modelRegs[r] - 16'd1;
				opBnz: begin
					if (modelRegs[r] != 16'd0) begin
						pc = w[addrWidth-1:0];
					end
				end
				opCall: begin
					retReg = pc;
					pend = 1'b1;
					pc = w[addrWidth-1:0];
				end
				opRet: begin
					if (!pend) begin
						break;
					end
					pc = retReg;
					pend = 1'b0;
				end
				opEmit: expEmits.push_back(modelRegs[r]);
				default: begin
				end
			endcase
		end
	endtask

	task automatic checkData(input dataT got, input dataT exp);
		checkCount++;
		if (got !== exp) begin
			$display("ERROR resultData got 0x%h expected 0x%h", got, exp);
			testErrors++;
		end
	endtask

	// Count of programDone pulses and emits still owed when one arrives
	task automatic checkDone(input int got, input int exp, input int owed);
		checkCount++;
		if (got != exp) begin
			$display("ERROR programDone count got 0x%h expected 0x%h", got, exp);
			testErrors++;
		end
		if (owed != 0) begin
			$display("programDone arrived with %0d expected emits still missing", owed);
			testErrors++;
		end
	endtask

	task automatic runTest(input int t);
		int base;
		int steps;
		int doneCount;
		int emitted;
		int cycles;
		testErrors = 0;
		base = (t % 4) * slotWords;
		genProgram(base);
		foreach (progWords[i]) begin
			@(negedge IsCall);
			progWe = 1'b1;
			progAddr = addrT'(base + i);
			progData = progWords[i];
			romImage[addrT'(base + i)] = progWords[i];
		end
		@(negedge IsCall);
		progWe = 1'b0;
		runModel(addrT'(base), steps);
		if (steps >= longestCycles) begin
			$display("Model never reached the final return of test %0d", t);
			testErrors++;
		end
		start = 1'b1;
		startAddr = addrT'(base);
		doneCount = 0;
		emitted = 0;
		for (cycles = 0; cycles < longestCycles; cycles++) begin
			@(negedge IsCall);
			start = 1'b0;
			if (resultValid) begin
				if (emitted < expEmits.size()) begin
					checkData(resultData, expEmits[emitted]);
				end else begin
					$display("resultValid pulsed beyond the expected emit sequence");
					testErrors++;
				end
				emitted++;
			end
			if (programDone) begin
				doneCount++;
				checkDone(doneCount, 1, expEmits.size() - emitted);
				// A few more cycles to catch output after the end
				if (doneCount == 1) begin
					cycles = longestCycles - 8;
				end
			end
		end
		if (doneCount == 0) begin
			$display("No programDone within %0d cycles of start", longestCycles);
			testErrors++;
		end
		$display("test %0d base 0x%h words %0d emits %0d %s", t, base, progWords.size(),
			expEmits.size(), testErrors == 0 ? "ok" : "FAILED");
		errorCount += testErrors;
	endtask

	initial begin
		rstN = 1'b0;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		start = 1'b0;
		startAddr = '0;
		repeat (10) @(negedge IsCall);
		rstN = 1'b1;
		// Outputs quiet until the first start
		repeat (20) begin
			@(negedge IsCall);
			checkCount++;
			if (resultValid !== 1'b0 || programDone !== 1'b0) begin
				$display("resultValid or programDone went high before any start");
				testErrors++;
			end
		end
		$display("test 0 idle after reset %s", testErrors == 0 ? "ok" : "FAILED");
		errorCount += testErrors;
		for (int t = 1; t <= numTests; t++) begin
			runTest(t);
		end
		$display("tests %0d checks %0d errors %0d", numTests + 1, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* microCore_props.sv */
`timescale 1ns/1ps

module microCore_props (
	input logic IsCall,
	input logic rstN,
	input logic start,
	input logic exeDone,
	input logic instrValid,
	input logic programDone
);

	// Instruction issued and not yet completed
	logic busy;
	// Idle from reset or the final return until the next start
	logic stopped;

	always_ff @(posedge IsCall) begin
		if (!rstN) begin
			busy <= 1'b0;
			stopped <= 1'b1;
		end else begin
			busy <= instrValid | (busy & ~exeDone);
			stopped <= programDone | (stopped & ~start);
		end
	end

	// Prefetched word issues exactly one cycle after every completion but the last
	// Never in the completion cycle itself
	nextAfterDone: assert property (@(posedge IsCall) disable iff (!rstN)
		exeDone && !programDone |-> !instrValid ##1 instrValid)
		else $error("instrValid not exactly one cycle after exeDone");

	oneAtATime: assert property (@(posedge IsCall) disable iff (!rstN)
		instrValid |-> !busy)
		else $error("instrValid issued again without an exeDone between");

	quietWhenStopped: assert property (@(posedge IsCall) disable iff (!rstN)
		stopped |-> !instrValid)
		else $error("instrValid after programDone before a new start");

endmodule

bind instructionFetch microCore_props microCore_props_i (
	.IsCall     (IsCall),
	.rstN       (rstN),
	.start      (start),
	.exeDone    (exeDone),
	.instrValid (instrValid),
	.programDone(programDone)
);

/* microCore.sv */
`timescale 1ns/1ps

module microCore #(
	parameter int addrWidth = 8
) (
	input  logic                 IsCall,
	input  logic                 rstN,
	input  logic                 progWe,
	input  logic [addrWidth-1:0] progAddr,
	input  microPkg::instrT      progData,
	input  logic                 start,
	input  logic [addrWidth-1:0] startAddr,
	output logic                 resultValid,
	output microPkg::dataT       resultData,
	output logic                 programDone
);
	import microPkg::*;

	// Fetch to ROM
	logic [addrWidth-1:0] fetchAddr1;
	logic [addrWidth-1:0] fetchAddr2;
	instrT word1;
	instrT word2;

	// Fetch to execute
	instrT instr;
	logic  instrValid;
	logic  callPending;

	// Execute to fetch
	logic exeDone;
	logic branchTaken;

	// Dual read ROM with the loader on its write port
	instrRom #(
		.addrWidth(addrWidth)
	) instrRom_i (
		.IsCall (IsCall),
		.we     (progWe),
		.wrAddr (progAddr),
		.wrData (progData),
		.rdAddr1(fetchAddr1),
		.rdAddr2(fetchAddr2),
		.rdData1(word1),
		.rdData2(word2)
	);

	instructionFetch #(
		.addrWidth(addrWidth)
	) instructionFetch_i (
		.IsCall     (IsCall),
		.rstN       (rstN),
		.start      (start),
		.startAddr  (startAddr),
		.word1      (word1),
		.word2      (word2),
		.exeDone    (exeDone),
		.branchTaken(branchTaken),
		.fetchAddr1 (fetchAddr1),
		.fetchAddr2 (fetchAddr2),
		.instr      (instr),
		.instrValid (instrValid),
		.callPending(callPending),
		.programDone(programDone)
	);

	execUnit execUnit_i (
		.IsCall     (IsCall),
		.rstN       (rstN),
		.instr      (instr),
		.instrValid (instrValid),
		.callPending(callPending),
		.exeDone    (exeDone),
		.branchTaken(branchTaken),
		.resultValid(resultValid),
		.resultData (resultData)
	);

endmodule

/* execUnit.sv */
`timescale 1ns/1ps

module execUnit (
	input  logic            IsCall,
	input  logic            rstN,
	input  microPkg::instrT instr,
	input  logic            instrValid,
	input  logic            callPending,
	output logic            exeDone,
	output logic            branchTaken,
	output logic            resultValid,
	output microPkg::dataT  resultData
);
	import microPkg::*;

	// Four general registers
	dataT regFile [4];

	// Decoded fields
	opcodeT op;
	regSelT sel;
	dataT   selVal;
	dataT   imm;

	// Multiply pipeline
	logic [1:0] mulCnt;
	regSelT     mulDst;
	dataT       mulA;
	dataT       mulB;
	dataT       mulProd;

	// Only a starting instruction decodes to anything but a no-op
	assign op = instrValid ? opcodeOf(instr) : opNop;
	assign sel = regOf(instr);
	assign selVal = regFile[sel];
	// Zero extended immediate
	assign imm = dataT'(immOf(instr));

	always_ff @(posedge IsCall) begin
		if (!rstN) begin
			for (int i = 0; i < 4; i++) begin
				regFile[i] <= '0;
			end
			exeDone <= 1'b0;
			branchTaken <= 1'b0;
			resultValid <= 1'b0;
			mulCnt <= '0;
		end else begin
			// Outcome signals are single cycle pulses
			branchTaken <= 1'b0;
			resultValid <= 1'b0;

			// Countdown for the three cycle multiply
			if (mulCnt != 2'd0) begin
				mulCnt <= mulCnt - 1'b1;
			end

			// Done one cycle after start unless multiplying
			if (mulCnt == 2'd1) begin
				exeDone <= 1'b1;
			end else begin
				exeDone <= instrValid && (op != opMuli);
			end

			// Multiply write back in the last pipeline step
			if (mulCnt == 2'd1) begin
				regFile[mulDst] <= mulProd;
			end

			case (op)
				opAddi: begin
					regFile[sel] <= selVal + imm;
				end
				opMuli: begin
					mulCnt <= 2'd2;
				end
				opDec: begin
					regFile[sel] <= selVal - 1'b1;
				end
				opBnz: begin
					branchTaken <= (selVal != '0);
				end
				opCall: begin
					branchTaken <= 1'b1;
				end
				opRet: begin
					// Only a pending call gives somewhere to go back to
					branchTaken <= callPending;
				end
				opEmit: begin
					resultValid <= 1'b1;
				end
				default: begin
					// opNop and spare codes just complete
				end
			endcase
		end
	end

	// Operand capture and product
	always_ff @(posedge IsCall) begin
		if (op == opMuli) begin
			mulA <= selVal;
			mulB <= imm;
			mulDst <= sel;
		end
		// Low 16 bits of the product kept
		if (mulCnt == 2'd2) begin
			mulProd <= mulA * mulB;
		end
	end

	// Emitted value travels with resultValid
	always_ff @(posedge IsCall) begin
		if (op == opEmit) begin
			resultData <= selVal;
		end
	end

endmodule

/* instructionFetch.sv */
`timescale 1ns/1ps

module instructionFetch #(
	parameter int addrWidth = 8
) (
	input  logic                 IsCall,
	input  logic                 rstN,
	input  logic                 start,
	input  logic [addrWidth-1:0] startAddr,
	input  microPkg::instrT      word1,
	input  microPkg::instrT      word2,
	input  logic                 exeDone,
	input  logic                 branchTaken,
	output logic [addrWidth-1:0] fetchAddr1,
	output logic [addrWidth-1:0] fetchAddr2,
	output microPkg::instrT      instr,
	output logic                 instrValid,
	output logic                 callPending,
	output logic                 programDone
);
	import microPkg::*;

	// Current instruction pointer
	logic [addrWidth-1:0] ip;
	logic [addrWidth-1:0] ipNext;
	// Single return register
	logic [addrWidth-1:0] retAddr;
	// Target field of the current instruction
	logic [addrWidth-1:0] target;

	opcodeT curOp;
	logic   callInstr;
	logic   retInstr;
	logic   lastInstr;
	logic   advance;

	// Start delay chain
	logic trigD1;
	logic trigD2;
	// exeDone delayed by one cycle
	logic doneD1;

	// Decode just what fetch needs
	assign curOp = opcodeOf(instr);
	assign callInstr = (curOp == opCall);
	assign retInstr = (curOp == opRet);

	assign ipNext = ip + 1'b1;
	assign target = instr[targetLsb +: addrWidth];

	// Port 1 reads the entry word in the start cycle
	// Otherwise always the fall-through word
	assign fetchAddr1 = start ? startAddr : ipNext;

	// Port 2 reads whatever a taken outcome would need
	assign fetchAddr2 = retInstr ? retAddr : target;

	// Return with nothing to return to ends the program
	assign lastInstr = retInstr & ~callPending;
	assign programDone = exeDone & lastInstr;

	// Move on to the next word on every other completion
	assign advance = exeDone & ~lastInstr;

	// New instruction two cycles after start or one after exeDone
	assign instrValid = trigD2 | doneD1;

	always_ff @(posedge IsCall) begin
		if (!rstN) begin
			trigD1 <= 1'b0;
			trigD2 <= 1'b0;
			doneD1 <= 1'b0;
		end else begin
			trigD1 <= start;
			trigD2 <= trigD1;
			// Stops here after the final return
			doneD1 <= advance;
		end
	end

	// Pointer follows the outcome chosen by execute
	always_ff @(posedge IsCall) begin
		if (!rstN) begin
			ip <= '0;
		end else if (start) begin
			ip <= startAddr;
		end else if (advance) begin
			ip <= branchTaken ? fetchAddr2 : ipNext;
		end
	end

	// Call and return bookkeeping
	always_ff @(posedge IsCall) begin
		if (!rstN) begin
			callPending <= 1'b0;
			retAddr <= '0;
		end else if (start) begin
			callPending <= 1'b0;
		end else if (advance && callInstr) begin
			// Resume at the word after the call
			callPending <= 1'b1;
			retAddr <= ipNext;
		end else if (advance && retInstr) begin
			callPending <= 1'b0;
		end
	end

	// Current instruction register
	// Both candidates are already waiting on the ROM ports
	always_ff @(posedge IsCall) begin
		if (trigD1) begin
			// Entry word read during the start cycle
			instr <= word1;
		end else if (advance) begin
			instr <= branchTaken ? word2 : word1;
		end
	end

	// instr holds between instrValid pulses
	// so the alternate address stays stable for a multi-cycle op

endmodule

/* instrRom.sv */
`timescale 1ns/1ps

module instrRom #(
	parameter int addrWidth = 8
) (
	input  logic                 IsCall,
	input  logic                 we,
	input  logic [addrWidth-1:0] wrAddr,
	input  microPkg::instrT      wrData,
	input  logic [addrWidth-1:0] rdAddr1,
	input  logic [addrWidth-1:0] rdAddr2,
	output microPkg::instrT      rdData1,
	output microPkg::instrT      rdData2
);
	import microPkg::*;

	// Full address space is backed
	localparam int depth = 1 << addrWidth;

	instrT mem [depth];

	// Program load port
	// Only written while the core is idle
	always_ff @(posedge IsCall) begin
		if (we) begin
			mem[wrAddr] <= wrData;
		end
	end

	// Fall-through word
	// Registered so the word shows up one cycle after its address
	always_ff @(posedge IsCall) begin
		rdData1 <= mem[rdAddr1];
	end

	// Taken word for branch, call or return target
	// Read in the same cycle as the fall-through word
	always_ff @(posedge IsCall) begin
		rdData2 <= mem[rdAddr2];
	end

	// Write and read addresses are fully independent
	// A read of the word being written returns the old content

endmodule

/* microPkg.sv */
package microPkg;

	// Instruction word
	localparam int instrWidth = 32;
	typedef logic [instrWidth-1:0] instrT;

	// Data word of the execute unit
	typedef logic [15:0] dataT;

	// Index into the four registers
	typedef logic [1:0] regSelT;

	// Opcode field values
	// Codes 8 to 15 fall through as no operation
	typedef enum logic [3:0] {
		opNop  = 4'd0,
		opAddi = 4'd1,
		opMuli = 4'd2,
		opDec  = 4'd3,
		opBnz  = 4'd4,
		opCall = 4'd5,
		opRet  = 4'd6,
		opEmit = 4'd7
	} opcodeT;

	// Field positions inside the instruction word
	localparam int opMsb = instrWidth - 1;
	localparam int opLsb = 28;
	localparam int regMsb = 27;
	localparam int regLsb = 26;
	localparam int immMsb = 23;
	localparam int immLsb = 16;
	// Target address occupies the low addrWidth bits
	localparam int targetLsb = 0;

	function automatic opcodeT opcodeOf(instrT w);
		return opcodeT'(w[opMsb:opLsb]);
	endfunction

	function automatic regSelT regOf(instrT w);
		return w[regMsb:regLsb];
	endfunction

	// Unsigned 8 bit immediate
	function automatic logic [immMsb-immLsb:0] immOf(instrT w);
		return w[immMsb:immLsb];
	endfunction

endpackage
